// File: rtl/commitPkg.sv
package commitPkg;

    localparam int tagWidth    = 4;
    localparam int tagCount    = 1 << tagWidth;
    localparam int entryWidth  = 23;
    localparam int rdWidth     = 5;
    localparam int pcLowWidth  = entryWidth - 1 - tagWidth - rdWidth;
    localparam int targetWidth = entryWidth - 1 - tagWidth;
    localparam int countWidth  = 16;

    // Kind bit selects the view of a queue word.
    localparam logic kindReg    = 1'b0;
    localparam logic kindBranch = 1'b1;

    // Register-writing operation.
    typedef struct packed {
        logic                  kind;
        logic [tagWidth-1:0]   tag;
        logic [rdWidth-1:0]    rd;
        logic [pcLowWidth-1:0] pcLow;
    } regView;

    // Branch operation whose target is used only on a mispredict.
    typedef struct packed {
        logic                   kind;
        logic [tagWidth-1:0]    tag;
        logic [targetWidth-1:0] target;
    } branchView;

    // Both views keep kind and tag in the top five bits.
    typedef union packed {
        regView    regFields;
        branchView branchFields;
    } commitEntry;

endpackage

// File: rtl/commitQueue.sv
`timescale 1ns/1ps

module commitQueue #(
    parameter int queueDepth = 8
) (
    input  logic                 Clk,
    input  logic                 arstN,
    input  logic                 writeEnable,
    input  commitPkg::commitEntry writeEntry,
    input  logic                 readEnable,
    input  logic                 clean,
    output commitPkg::commitEntry readEntry,
    output commitPkg::commitEntry headEntry,
    output commitPkg::commitEntry lastEntry,
    output logic                 full,
    output logic                 empty
);

    import commitPkg::*;

    // One spare slot tells full from empty.
    localparam int slotCount = queueDepth + 1;
    localparam int ptrWidth  = $clog2(slotCount);

    localparam logic [ptrWidth-1:0] lastSlot   = ptrWidth'(queueDepth);
    localparam logic [ptrWidth:0]   slotCountW = (ptrWidth + 1)'(slotCount);
    localparam logic [ptrWidth:0]   depthW     = (ptrWidth + 1)'(queueDepth);

    commitEntry slots [0:queueDepth];

    logic [ptrWidth-1:0] headPtr;
    logic [ptrWidth-1:0] tailPtr;
    logic [ptrWidth-1:0] lastPtr;
    logic [ptrWidth:0]   used;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        nextPtr = (ptr == lastSlot) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
        end else if (clean) begin
            headPtr <= '0;
            tailPtr <= '0;
        end else begin
            if (writeEnable) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (readEnable) begin
                headPtr <= nextPtr(headPtr);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (writeEnable) begin
            slots[tailPtr] <= writeEntry;
        end
        if (readEnable) begin
            readEntry <= slots[headPtr];
        end
    end

    // Occupancy modulo the slot count.
    always_comb begin
        if (tailPtr >= headPtr) begin
            used = {1'b0, tailPtr} - {1'b0, headPtr};
        end else begin
            used = {1'b0, tailPtr} + slotCountW - {1'b0, headPtr};
        end
    end

    assign lastPtr   = (tailPtr == '0) ? lastSlot : tailPtr - 1'b1;
    assign empty     = (headPtr == tailPtr);
    assign full      = (used == depthW);
    assign headEntry = slots[headPtr];
    assign lastEntry = empty ? commitEntry'('0) : slots[lastPtr];

endmodule

// File: rtl/dispatchPack.sv
`timescale 1ns/1ps

module dispatchPack (
    input  logic                              Clk,
    input  logic                              arstN,
    input  logic                              dispatchValid,
    input  logic                              dispatchReady,
    input  logic                              dispatchKind,
    input  logic [commitPkg::rdWidth-1:0]     dispatchRd,
    input  logic [commitPkg::pcLowWidth-1:0]  dispatchPcLow,
    input  logic [commitPkg::targetWidth-1:0] dispatchTarget,
    input  logic                              flush,
    output logic                              writeEnable,
    output commitPkg::commitEntry             writeEntry
);

    import commitPkg::*;

    logic [tagWidth-1:0] nextTag;

    assign writeEnable = dispatchValid && dispatchReady;

    // Tags restart at zero after a redirect.
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            nextTag <= '0;
        end else if (flush) begin
            nextTag <= '0;
        end else if (writeEnable) begin
            nextTag <= nextTag + 1'b1;
        end
    end

    always_comb begin
        writeEntry = '0;
        if (dispatchKind == kindBranch) begin
            writeEntry.branchFields.kind   = kindBranch;
            writeEntry.branchFields.tag    = nextTag;
            writeEntry.branchFields.target = dispatchTarget;
        end else begin
            writeEntry.regFields.kind  = kindReg;
            writeEntry.regFields.tag   = nextTag;
            writeEntry.regFields.rd    = dispatchRd;
            writeEntry.regFields.pcLow = dispatchPcLow;
        end
    end

endmodule

// File: rtl/doneTable.sv
`timescale 1ns/1ps

module doneTable (
    input  logic                           Clk,
    input  logic                           arstN,
    input  logic                           wbValid,
    input  logic [commitPkg::tagWidth-1:0] wbTag,
    input  logic                           wbMispredict,
    input  logic [commitPkg::tagWidth-1:0] headTag,
    input  logic                           retireTagClear,
    input  logic                           flush,
    output logic                           headDone,
    output logic                           headMispredict
);

    import commitPkg::*;

    logic [tagCount-1:0] doneBits;
    logic [tagCount-1:0] mispredictBits;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            doneBits       <= '0;
            mispredictBits <= '0;
        end else if (flush) begin
            doneBits       <= '0;
            mispredictBits <= '0;
        end else begin
            if (retireTagClear) begin
                doneBits[headTag]       <= 1'b0;
                mispredictBits[headTag] <= 1'b0;
            end
            // A writeback to a reused tag wins over the clear.
            if (wbValid) begin
                doneBits[wbTag]       <= 1'b1;
                mispredictBits[wbTag] <= wbMispredict;
            end
        end
    end

    assign headDone       = doneBits[headTag];
    assign headMispredict = mispredictBits[headTag];

endmodule

// File: rtl/commitCtrl.sv
`timescale 1ns/1ps

module commitCtrl #(
    parameter int queueDepth = 8
) (
    input  logic Clk,
    input  logic arstN,
    input  logic empty,
    input  logic full,
    input  logic headDone,
    input  logic headMispredict,
    input  logic flush,
    output logic readEnable,
    output logic retireTagClear,
    output logic retireStrobe,
    output logic retireMispredict,
    output logic dispatchReady
);

    import commitPkg::*;

    // Queued entries need distinct tags.
    if (queueDepth > tagCount) begin : depthCheck
        $error("queueDepth exceeds the tag space");
    end

    // No pop in the redirect cycle because the younger head is being flushed.
    assign readEnable     = !empty && headDone && !flush;
    assign retireTagClear = readEnable;
    assign dispatchReady  = !full && !flush;

    // Lines the retire decision up with the registered queue output.
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            retireStrobe     <= 1'b0;
            retireMispredict <= 1'b0;
        end else begin
            retireStrobe     <= readEnable;
            retireMispredict <= readEnable && headMispredict;
        end
    end

endmodule

// File: rtl/retireDecode.sv
`timescale 1ns/1ps

module retireDecode (
    input  logic                              Clk,
    input  logic                              arstN,
    input  logic                              retireStrobe,
    input  logic                              retireMispredict,
    input  commitPkg::commitEntry             readEntry,
    output logic                              commitValid,
    output logic [commitPkg::rdWidth-1:0]     commitRd,
    output logic [commitPkg::tagWidth-1:0]    commitTag,
    output logic                              redirectValid,
    output logic [commitPkg::targetWidth-1:0] redirectTarget,
    output logic                              flush,
    output logic [commitPkg::countWidth-1:0]  retiredCount
);

    import commitPkg::*;

    logic isBranch;

    assign isBranch = (readEntry.branchFields.kind == kindBranch);

    assign commitValid = retireStrobe && !isBranch;
    assign commitRd    = readEntry.regFields.rd;
    assign commitTag   = readEntry.regFields.tag;

    // A correctly predicted branch retires without a redirect.
    assign redirectValid  = retireStrobe && isBranch && retireMispredict;
    assign redirectTarget = readEntry.branchFields.target;
    assign flush          = redirectValid;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            retiredCount <= '0;
        end else if (retireStrobe) begin
            retiredCount <= retiredCount + 1'b1;
        end
    end

endmodule

// File: rtl/commitTop.sv
`timescale 1ns/1ps

module commitTop #(
    parameter int queueDepth = 8
) (
    input  logic                              Clk,
    input  logic                              arstN,
    input  logic                              dispatchValid,
    input  logic                              dispatchKind,
    input  logic [commitPkg::rdWidth-1:0]     dispatchRd,
    input  logic [commitPkg::pcLowWidth-1:0]  dispatchPcLow,
    input  logic [commitPkg::targetWidth-1:0] dispatchTarget,
    input  logic                              wbValid,
    input  logic [commitPkg::tagWidth-1:0]    wbTag,
    input  logic                              wbMispredict,
    output logic                              dispatchReady,
    output logic                              commitValid,
    output logic [commitPkg::rdWidth-1:0]     commitRd,
    output logic [commitPkg::tagWidth-1:0]    commitTag,
    output logic                              redirectValid,
    output logic [commitPkg::targetWidth-1:0] redirectTarget,
    output logic [commitPkg::countWidth-1:0]  retiredCount
);

    import commitPkg::*;

    commitEntry          writeEntry;
    commitEntry          readEntry;
    commitEntry          headEntry;
    logic                writeEnable;
    logic                readEnable;
    logic                full;
    logic                empty;
    logic                flush;
    logic [tagWidth-1:0] headTag;
    logic                headDone;
    logic                headMispredict;
    logic                retireTagClear;
    logic                retireStrobe;
    logic                retireMispredict;

    assign headTag = headEntry.regFields.tag;

    dispatchPack i_dispatch (
        .Clk            (Clk),
        .arstN          (arstN),
        .dispatchValid  (dispatchValid),
        .dispatchReady  (dispatchReady),
        .dispatchKind   (dispatchKind),
        .dispatchRd     (dispatchRd),
        .dispatchPcLow  (dispatchPcLow),
        .dispatchTarget (dispatchTarget),
        .flush          (flush),
        .writeEnable    (writeEnable),
        .writeEntry     (writeEntry)
    );

    commitQueue #(
        .queueDepth (queueDepth)
    ) i_queue (
        .Clk         (Clk),
        .arstN       (arstN),
        .writeEnable (writeEnable),
        .writeEntry  (writeEntry),
        .readEnable  (readEnable),
        .clean       (flush),
        .readEntry   (readEntry),
        .headEntry   (headEntry),
        .lastEntry   (),
        .full        (full),
        .empty       (empty)
    );

    doneTable i_done (
        .Clk            (Clk),
        .arstN          (arstN),
        .wbValid        (wbValid),
        .wbTag          (wbTag),
        .wbMispredict   (wbMispredict),
        .headTag        (headTag),
        .retireTagClear (retireTagClear),
        .flush          (flush),
        .headDone       (headDone),
        .headMispredict (headMispredict)
    );

    commitCtrl #(
        .queueDepth (queueDepth)
    ) i_ctrl (
        .Clk              (Clk),
        .arstN            (arstN),
        .empty            (empty),
        .full             (full),
        .headDone         (headDone),
        .headMispredict   (headMispredict),
        .flush            (flush),
        .readEnable       (readEnable),
        .retireTagClear   (retireTagClear),
        .retireStrobe     (retireStrobe),
        .retireMispredict (retireMispredict),
        .dispatchReady    (dispatchReady)
    );

    retireDecode i_retire (
        .Clk              (Clk),
        .arstN            (arstN),
        .retireStrobe     (retireStrobe),
        .retireMispredict (retireMispredict),
        .readEntry        (readEntry),
        .commitValid      (commitValid),
        .commitRd         (commitRd),
        .commitTag        (commitTag),
        .redirectValid    (redirectValid),
        .redirectTarget   (redirectTarget),
        .flush            (flush),
        .retiredCount     (retiredCount)
    );

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter real halfPeriod  = 2.0,
    parameter int  resetCycles = 10
) (
    output logic Clk,
    output logic arstN
);

    initial begin
        Clk = 1'b0;
        forever begin
            #(halfPeriod) Clk = ~Clk;
        end
    end

    // Release lands between edges.
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge Clk);
        #1 arstN = 1'b1;
    end

endmodule

// File: bench/commitTb.sv
`timescale 1ns/1ps

module commitTb;

    import commitPkg::*;

    localparam int    queueDepth = 8;
    localparam int    waitLimit  = 64;
    localparam string testFile   = "bench/commitTests.txt";

    logic                   Clk;
    logic                   arstN;
    logic                   dispatchValid;
    logic                   dispatchKind;
    logic [rdWidth-1:0]     dispatchRd;
    logic [pcLowWidth-1:0]  dispatchPcLow;
    logic [targetWidth-1:0] dispatchTarget;
    logic                   wbValid;
    logic [tagWidth-1:0]    wbTag;
    logic                   wbMispredict;
    logic                   dispatchReady;
    logic                   commitValid;
    logic [rdWidth-1:0]     commitRd;
    logic [tagWidth-1:0]    commitTag;
    logic                   redirectValid;
    logic [targetWidth-1:0] redirectTarget;
    logic [countWidth-1:0]  retiredCount;

    // Pulses that are seen and not yet matched queue up oldest first.
    logic [rdWidth+tagWidth-1:0] commitSeen [$];
    logic [targetWidth-1:0]      redirectSeen [$];

    int    fileHandle;
    int    status;
    string line;

    clockGen i_clock (
        .Clk   (Clk),
        .arstN (arstN)
    );

    commitTop #(
        .queueDepth (queueDepth)
    ) i_dut (
        .Clk            (Clk),
        .arstN          (arstN),
        .dispatchValid  (dispatchValid),
        .dispatchKind   (dispatchKind),
        .dispatchRd     (dispatchRd),
        .dispatchPcLow  (dispatchPcLow),
        .dispatchTarget (dispatchTarget),
        .wbValid        (wbValid),
        .wbTag          (wbTag),
        .wbMispredict   (wbMispredict),
        .dispatchReady  (dispatchReady),
        .commitValid    (commitValid),
        .commitRd       (commitRd),
        .commitTag      (commitTag),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget),
        .retiredCount   (retiredCount)
    );

    // Outputs move only after a rising edge, so the edge sees the cycle just ended.
    always @(posedge Clk) begin
        if (commitValid) begin
            commitSeen.push_back({commitRd, commitTag});
        end
        if (redirectValid) begin
            redirectSeen.push_back(redirectTarget);
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] want,
                              input logic [31:0] got);
        assert (got === want) else begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, want, got);
            abortRun("a checked value did not match");
        end
    endtask

    task automatic fieldCheck(input int got, input int want, input string text);
        assert (got == want) else abortRun({"malformed line in test file: ", text});
    endtask

    task automatic dispatchOp(input logic kind, input logic [31:0] value,
                              input logic [31:0] pcLow);
        int waited;
        waited = 0;
        while (dispatchReady !== 1'b1) begin
            if (waited == waitLimit) begin
                abortRun("dispatchReady stayed low too long");
            end else begin
                waited++;
                @(negedge Clk);
            end
        end
        dispatchValid  = 1'b1;
        dispatchKind   = kind;
        dispatchRd     = value[rdWidth-1:0];
        dispatchTarget = value[targetWidth-1:0];
        dispatchPcLow  = pcLow[pcLowWidth-1:0];
        @(negedge Clk);
        dispatchValid = 1'b0;
    endtask

    task automatic writebackOp(input logic [tagWidth-1:0] tag, input logic mispredict);
        wbValid      = 1'b1;
        wbTag        = tag;
        wbMispredict = mispredict;
        @(negedge Clk);
        wbValid = 1'b0;
    endtask

    task automatic expectCommit(input string name, input logic [31:0] rd,
                                input logic [31:0] tag);
        logic [rdWidth+tagWidth-1:0] seen;
        int                          waited;
        waited = 0;
        while (commitSeen.size() == 0) begin
            if (waited == waitLimit) begin
                abortRun({"no commit pulse arrived for ", name});
            end else begin
                waited++;
                @(negedge Clk);
            end
        end
        seen = commitSeen.pop_front();
        checkValue({name, " rd"}, rd, seen[tagWidth +: rdWidth]);
        checkValue({name, " tag"}, tag, seen[tagWidth-1:0]);
    endtask

    task automatic expectRedirect(input string name, input logic [31:0] target);
        int waited;
        waited = 0;
        while (redirectSeen.size() == 0) begin
            if (waited == waitLimit) begin
                abortRun({"no redirect pulse arrived for ", name});
            end else begin
                waited++;
                @(negedge Clk);
            end
        end
        checkValue(name, target, redirectSeen.pop_front());
    endtask

    // Any pulse inside the window is one nobody expected.
    task automatic expectQuiet(input string name, input logic [31:0] cycles);
        repeat (cycles) @(negedge Clk);
        checkValue({name, " commits"}, 0, commitSeen.size());
        checkValue({name, " redirects"}, 0, redirectSeen.size());
    endtask

    task automatic runLine(input string text);
        string       cmd;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          fields;
        fields = $sscanf(text, "%s", cmd);
        case (cmd)
            "D": begin
                fields = $sscanf(text, "%s %h %h %h", cmd, a, b, c);
                fieldCheck(fields, 4, text);
                dispatchOp(a[0], b, c);
            end
            "W": begin
                fields = $sscanf(text, "%s %h %h", cmd, a, b);
                fieldCheck(fields, 3, text);
                writebackOp(a[tagWidth-1:0], b[0]);
            end
            "C": begin
                fields = $sscanf(text, "%s %s %h %h", cmd, name, a, b);
                fieldCheck(fields, 4, text);
                expectCommit(name, a, b);
            end
            "R", "Y", "N", "Q": begin
                fields = $sscanf(text, "%s %s %h", cmd, name, a);
                fieldCheck(fields, 3, text);
                case (cmd)
                    "R": expectRedirect(name, a);
                    "Y": checkValue(name, a, dispatchReady);
                    "N": checkValue(name, a, retiredCount);
                    default: expectQuiet(name, a);
                endcase
            end
            default: abortRun({"unknown step in test file: ", text});
        endcase
    endtask

    initial begin
        int waited;
        dispatchValid  = 1'b0;
        dispatchKind   = kindReg;
        dispatchRd     = '0;
        dispatchPcLow  = '0;
        dispatchTarget = '0;
        wbValid        = 1'b0;
        wbTag          = '0;
        wbMispredict   = 1'b0;
        waited         = 0;
        while (arstN !== 1'b1) begin
            if (waited == waitLimit) begin
                abortRun("reset was never released");
            end else begin
                waited++;
                @(negedge Clk);
            end
        end
        @(negedge Clk);
        fileHandle = $fopen(testFile, "r");
        assert (fileHandle != 0) else abortRun({"cannot open ", testFile});
        while (!$feof(fileHandle)) begin
            line   = "";
            status = $fgets(line, fileHandle);
            if (status > 0 && line.len() > 1 && line.getc(0) != "#") begin
                runLine(line);
            end
        end
        $fclose(fileHandle);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: bench/commitTests.txt
# Values are hex. D kind rdOrTarget pcLow | W tag mispredict | C name rd tag
# R name target | Y name readyLevel | N name retiredCount | Q name quietCycles
Y resetReady 1
N resetCount 0
Q resetQuiet 5
D 0 01 0100
D 0 02 0104
D 0 03 0108
D 0 04 010c
W 3 0
W 2 0
W 1 0
W 0 0
C inOrder0 01 0
C inOrder1 02 1
C inOrder2 03 2
C inOrder3 04 3
N countAfterInOrder 4
D 0 05 0200
D 1 2abcd 0204
D 0 06 0208
D 0 07 020c
D 0 08 0210
D 0 09 0214
D 0 0a 0218
D 0 0b 021c
Y fullNotReady 0
W 4 0
C headRetire 05 4
Y readyAgain 1
W 7 0
W 6 0
W 5 1
R mispredictTarget 2abcd
Q flushQuiet 8
D 0 1f 0300
W 0 0
C tagAfterFlush 1f 0
D 1 12345 0304
W 1 0
Q correctBranchQuiet 6
N finalCount 8

// File: all.f
rtl/commitPkg.sv
rtl/commitQueue.sv
rtl/dispatchPack.sv
rtl/doneTable.sv
rtl/commitCtrl.sv
rtl/retireDecode.sv
rtl/commitTop.sv
bench/clockGen.sv
bench/commitTb.sv
